// ==== Bender.yml ====
package:
  name: afu_shell

sources:
  - files:
      - design/ccip_types_pkg.sv
      - design/afu_csr_pkg.sv
      - design/csr_decode.sv
      - design/active_line_tracker.sv
      - design/read_engine.sv
      - design/rsp_accumulator.sv
      - design/afu_shell.sv
  - target: simulation
    files:
      - dv/host_mem_model.sv
      - dv/afu_shell_tb.sv

// ==== design/active_line_tracker.sv ====
// active line tracker: counts outstanding reads and forces almost-full at the limit
`timescale 1ns/1ps
`default_nettype none

module active_line_tracker
(
    input  wire logic                               afu_clk,
    input  wire logic                               rst_n,
    input  wire logic                               req_fire,
    input  wire logic                               rsp_valid,
    input  wire logic [afu_csr_pkg::LIMIT_W-1:0]    active_limit,
    output logic                                    almost_full
);
    import afu_csr_pkg::*;

    // counter wide enough to hold MAX_ACTIVE, saturating at both ends
    logic [LIMIT_W-1:0] active_q;

    // a request and a response in the same cycle cancel out
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active_q <= '0;
        end
        else
        begin
            case ({req_fire, rsp_valid})
                2'b10:
                begin
                    if (active_q != '1)
                    begin
                        active_q <= active_q + 1'b1;
                    end
                end
                2'b01:
                begin
                    if (active_q != '0)
                    begin
                        active_q <= active_q - 1'b1;
                    end
                end
                default:
                begin
                    active_q <= active_q;
                end
            endcase
        end
    end

    // from the registered count, so a transfer is felt one cycle later
    // and the host may briefly see one line above the limit
    assign almost_full = (active_q >= active_limit);

endmodule

`default_nettype wire

// ==== design/afu_csr_pkg.sv ====
// afu register map: csr addresses, the write data decode union and run structs
`default_nettype none

package afu_csr_pkg;

    // ======================================================================
    // register map
    // ======================================================================

    localparam logic [ccip_types_pkg::MMIO_ADDR_W-1:0] CSR_CMD      = 16'h0000;
    localparam logic [ccip_types_pkg::MMIO_ADDR_W-1:0] CSR_LIMIT    = 16'h0008;
    localparam logic [ccip_types_pkg::MMIO_ADDR_W-1:0] CSR_STATUS   = 16'h0010;
    localparam logic [ccip_types_pkg::MMIO_ADDR_W-1:0] CSR_CHECKSUM = 16'h0018;

    // largest active-line limit the host may program
    localparam int MAX_ACTIVE = 64;
    // one spare bit so the limit register can hold MAX_ACTIVE itself
    localparam int LIMIT_W    = $clog2(MAX_ACTIVE) + 1;
    // width of a line count for one run
    localparam int CNT_W      = 16;

    // ======================================================================
    // mmio write data decode
    // ======================================================================

    // command word: base in the upper half, start in bit 0
    typedef struct packed {
        logic [ccip_types_pkg::LINE_ADDR_W-1:0] base;
        logic [CNT_W-1:0]                       count;
        logic [14:0]                            pad;
        logic                                   start;
    } cmd_word_t;

    // limit word: the active limit sits in the low bits
    typedef struct packed {
        logic [ccip_types_pkg::DATA_W-LIMIT_W-1:0] pad;
        logic [LIMIT_W-1:0]                        active_limit;
    } limit_word_t;

    // the same 64-bit write data, read as a command or as a limit
    typedef union packed {
        cmd_word_t   cmd;
        limit_word_t limit;
    } csr_word_u;

    // start pulse with the run parameters, from decode to the engines
    typedef struct packed {
        logic                                   start;
        logic [ccip_types_pkg::LINE_ADDR_W-1:0] base;
        logic [CNT_W-1:0]                       count;
    } run_cmd_t;

    // run result, from the accumulator back to the register block
    typedef struct packed {
        logic                              done;
        logic [CNT_W-1:0]                  rsp_count;
        logic [ccip_types_pkg::DATA_W-1:0] checksum;
    } run_status_t;

endpackage

`default_nettype wire

// ==== design/afu_shell.sv ====
// afu top level: registers power and error, then joins the csr, read and sum paths
`timescale 1ns/1ps
`default_nettype none

module afu_shell
(
    input  wire logic                       afu_clk,
    input  wire logic                       rst_n,
    input  wire logic [1:0]                 pwr_state,
    input  wire logic                       error,
    input  wire ccip_types_pkg::host_rx_t   host_rx,
    output ccip_types_pkg::host_tx_t        host_tx
);
    import ccip_types_pkg::*;
    import afu_csr_pkg::*;

    // ======================================================================
    // edge registers for the sideband inputs
    // ======================================================================

    logic [1:0] pwr_state_q;
    logic       error_q;

    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pwr_state_q <= 2'b00;
            error_q     <= 1'b0;
        end
        else
        begin
            pwr_state_q <= pwr_state;
            error_q     <= error;
        end
    end

    // ======================================================================
    // blocks
    // ======================================================================

    run_cmd_t               cmd;
    run_status_t            status;
    logic [LIMIT_W-1:0]     active_limit;
    logic                   almost_full;
    logic                   req_fire;
    logic                   req_valid;
    logic [LINE_ADDR_W-1:0] req_addr;
    logic [TAG_W-1:0]       req_tag;
    logic                   mmio_rsp_valid;
    logic [DATA_W-1:0]      mmio_rsp_data;

    csr_decode u_csr_decode
    (
        .afu_clk        (afu_clk),
        .rst_n          (rst_n),
        .host_rx        (host_rx),
        .pwr_state      (pwr_state_q),
        .error          (error_q),
        .status         (status),
        .cmd            (cmd),
        .active_limit   (active_limit),
        .mmio_rsp_valid (mmio_rsp_valid),
        .mmio_rsp_data  (mmio_rsp_data)
    );

    // throttles the engine the way a forced almost-full would
    active_line_tracker u_tracker
    (
        .afu_clk      (afu_clk),
        .rst_n        (rst_n),
        .req_fire     (req_fire),
        .rsp_valid    (host_rx.rsp_valid),
        .active_limit (active_limit),
        .almost_full  (almost_full)
    );

    read_engine u_read_engine
    (
        .afu_clk     (afu_clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .almost_full (almost_full),
        .req_ready   (host_rx.req_ready),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_tag     (req_tag),
        .req_fire    (req_fire)
    );

    rsp_accumulator u_rsp_accumulator
    (
        .afu_clk   (afu_clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .rsp_valid (host_rx.rsp_valid),
        .rsp_data  (host_rx.rsp_data),
        .status    (status)
    );

    // rsp_tag is not needed since the sum ignores arrival order
    assign host_tx = '{req_valid:      req_valid,
                       req_addr:       req_addr,
                       req_tag:        req_tag,
                       mmio_rsp_valid: mmio_rsp_valid,
                       mmio_rsp_data:  mmio_rsp_data};

endmodule

`default_nettype wire

// ==== design/ccip_types_pkg.sv ====
// host channel types: bus widths and the packed receive and transmit structs
`default_nettype none

package ccip_types_pkg;

    // ======================================================================
    // bus widths
    // ======================================================================

    // cache lines are addressed by line index, not by byte
    localparam int LINE_ADDR_W = 32;
    // read data and mmio data share one 64-bit width
    localparam int DATA_W      = 64;
    localparam int TAG_W       = 8;
    localparam int MMIO_ADDR_W = 16;

    // ======================================================================
    // channel structs
    // ======================================================================

    // host to afu direction
    // mmio requests and read responses have no back-pressure, so they carry
    // valid only; req_ready is the one flow-control signal toward the afu
    typedef struct packed {
        logic                   mmio_valid;
        logic                   mmio_write;
        logic [MMIO_ADDR_W-1:0] mmio_addr;
        logic [DATA_W-1:0]      mmio_data;
        logic                   req_ready;
        logic                   rsp_valid;
        logic [TAG_W-1:0]       rsp_tag;
        logic [DATA_W-1:0]      rsp_data;
    } host_rx_t;

    // afu to host direction
    // the line read request uses a valid/ready handshake with req_ready above
    typedef struct packed {
        logic                   req_valid;
        logic [LINE_ADDR_W-1:0] req_addr;
        logic [TAG_W-1:0]       req_tag;
        logic                   mmio_rsp_valid;
        logic [DATA_W-1:0]      mmio_rsp_data;
    } host_tx_t;

endpackage

`default_nettype wire

// ==== design/csr_decode.sv ====
// mmio register block: decodes writes into run commands and answers reads
`timescale 1ns/1ps
`default_nettype none

module csr_decode
(
    input  wire logic                                afu_clk,
    input  wire logic                                rst_n,
    input  wire ccip_types_pkg::host_rx_t            host_rx,
    input  wire logic [1:0]                          pwr_state,
    input  wire logic                                error,
    input  wire afu_csr_pkg::run_status_t            status,
    output afu_csr_pkg::run_cmd_t                    cmd,
    output logic [afu_csr_pkg::LIMIT_W-1:0]          active_limit,
    output logic                                     mmio_rsp_valid,
    output logic [ccip_types_pkg::DATA_W-1:0]        mmio_rsp_data
);
    import ccip_types_pkg::*;
    import afu_csr_pkg::*;

    // one view of the write data, decoded per address below
    csr_word_u         wr_word;
    logic              wr_fire;
    logic              rd_fire;

    logic              start_q;
    logic [LINE_ADDR_W-1:0] base_q;
    logic [CNT_W-1:0]  count_q;
    logic [LIMIT_W-1:0] limit_q;
    logic              err_q;
    logic [DATA_W-1:0] rd_data;

    assign wr_word = host_rx.mmio_data;
    assign wr_fire = host_rx.mmio_valid & host_rx.mmio_write;
    assign rd_fire = host_rx.mmio_valid & ~host_rx.mmio_write;

    // ======================================================================
    // write side
    // ======================================================================

    // the start pulse lasts exactly one cycle, the cycle after the write
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            start_q <= 1'b0;
            limit_q <= LIMIT_W'(MAX_ACTIVE);
        end
        else
        begin
            start_q <= wr_fire && (host_rx.mmio_addr == CSR_CMD) && wr_word.cmd.start;
            if (wr_fire && (host_rx.mmio_addr == CSR_LIMIT))
            begin
                limit_q <= wr_word.limit.active_limit;
            end
        end
    end

    // run parameters follow every command write and are sampled on start
    always_ff @(posedge afu_clk)
    begin
        if (wr_fire && (host_rx.mmio_addr == CSR_CMD))
        begin
            base_q  <= wr_word.cmd.base;
            count_q <= wr_word.cmd.count;
        end
    end

    // sticky error, set by the registered error input and cleared by start
    // a new error in the start cycle still wins
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            err_q <= 1'b0;
        end
        else if (error)
        begin
            err_q <= 1'b1;
        end
        else if (start_q)
        begin
            err_q <= 1'b0;
        end
    end

    assign cmd = '{start: start_q, base: base_q, count: count_q};
    assign active_limit = limit_q;

    // ======================================================================
    // read side
    // ======================================================================

    // status packs done, error and power state low and the count in 31:16
    always_comb
    begin
        case (host_rx.mmio_addr)
            CSR_STATUS:   rd_data = {32'b0, status.rsp_count, 12'b0, pwr_state, err_q,
                                     status.done};
            CSR_CHECKSUM: rd_data = status.checksum;
            default:      rd_data = '0;
        endcase
    end

    // the response is always one cycle after the read request
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mmio_rsp_valid <= 1'b0;
        end
        else
        begin
            mmio_rsp_valid <= rd_fire;
        end
    end

    always_ff @(posedge afu_clk)
    begin
        if (rd_fire)
        begin
            mmio_rsp_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/read_engine.sv ====
// read engine: walks the programmed line range and issues tagged read requests
`timescale 1ns/1ps
`default_nettype none

module read_engine
(
    input  wire logic                                   afu_clk,
    input  wire logic                                   rst_n,
    input  wire afu_csr_pkg::run_cmd_t                  cmd,
    input  wire logic                                   almost_full,
    input  wire logic                                   req_ready,
    output logic                                        req_valid,
    output logic [ccip_types_pkg::LINE_ADDR_W-1:0]      req_addr,
    output logic [ccip_types_pkg::TAG_W-1:0]            req_tag,
    output logic                                        req_fire
);
    import ccip_types_pkg::*;
    import afu_csr_pkg::*;

    logic                   valid_q;
    logic [CNT_W-1:0]       remain_q;
    logic [CNT_W-1:0]       remain_next;
    logic [LINE_ADDR_W-1:0] addr_q;
    // tag is the low bits of the request index
    logic [TAG_W-1:0]       tag_q;

    assign req_fire    = valid_q & req_ready;
    assign remain_next = req_fire ? remain_q - 1'b1 : remain_q;

    // ======================================================================
    // handshake control
    // ======================================================================

    // valid only changes when idle or on a transfer, so a request that is
    // up stays up under back-pressure even if almost_full rises meanwhile
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q  <= 1'b0;
            remain_q <= '0;
        end
        else if (cmd.start)
        begin
            valid_q  <= 1'b0;
            remain_q <= cmd.count;
        end
        else
        begin
            remain_q <= remain_next;
            if (!valid_q || req_fire)
            begin
                valid_q <= (remain_next != '0) && !almost_full;
            end
        end
    end

    // address and tag advance only on a transfer
    always_ff @(posedge afu_clk)
    begin
        if (cmd.start)
        begin
            addr_q <= cmd.base;
            tag_q  <= '0;
        end
        else if (req_fire)
        begin
            addr_q <= addr_q + 1'b1;
            tag_q  <= tag_q + 1'b1;
        end
    end

    assign req_valid = valid_q;
    assign req_addr  = addr_q;
    assign req_tag   = tag_q;

endmodule

`default_nettype wire

// ==== design/rsp_accumulator.sv ====
// response accumulator: sums returned read data and flags the end of a run
`timescale 1ns/1ps
`default_nettype none

module rsp_accumulator
(
    input  wire logic                               afu_clk,
    input  wire logic                               rst_n,
    input  wire afu_csr_pkg::run_cmd_t              cmd,
    input  wire logic                               rsp_valid,
    input  wire logic [ccip_types_pkg::DATA_W-1:0]  rsp_data,
    output afu_csr_pkg::run_status_t                status
);
    import ccip_types_pkg::*;
    import afu_csr_pkg::*;

    logic              done_q;
    logic [CNT_W-1:0]  count_q;
    logic [CNT_W-1:0]  target_q;
    logic [DATA_W-1:0] sum_q;

    // addition is order independent, so out-of-order return needs no tags
    // the sum wraps modulo 2**64
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            done_q   <= 1'b0;
            count_q  <= '0;
            target_q <= '0;
            sum_q    <= '0;
        end
        else if (cmd.start)
        begin
            done_q   <= 1'b0;
            count_q  <= '0;
            target_q <= cmd.count;
            sum_q    <= '0;
        end
        else if (rsp_valid)
        begin
            count_q <= count_q + 1'b1;
            sum_q   <= sum_q + rsp_data;
            // done rises the cycle after the last response and holds
            if (count_q + 1'b1 == target_q)
            begin
                done_q <= 1'b1;
            end
        end
    end

    assign status = '{done: done_q, rsp_count: count_q, checksum: sum_q};

endmodule

`default_nettype wire

// ==== dv/afu_shell_tb.sv ====
// testbench top for the afu shell with mmio access, port assertions and run readback
`timescale 1ns/1ps
`default_nettype none

module afu_shell_tb;
    import ccip_types_pkg::*;
    import afu_csr_pkg::*;

    // three runs of 20, 40 and 300 lines
    localparam int TOTAL_LINES     = 20 + 40 + 300;
    localparam int WATCHDOG_CYCLES = TOTAL_LINES * 200 + 2000;
    localparam logic [DATA_W-1:0] DATA_XOR = 64'hA5A5_0000_5A5A_0000;

    logic                   afu_clk;
    logic                   rst_n;
    logic [1:0]             pwr_state;
    logic                   error;
    logic                   mmio_valid;
    logic                   mmio_write;
    logic [MMIO_ADDR_W-1:0] mmio_addr;
    logic [DATA_W-1:0]      mmio_data;
    logic                   req_ready;
    logic                   rsp_valid;
    logic [TAG_W-1:0]       rsp_tag;
    logic [DATA_W-1:0]      rsp_data;
    host_rx_t               host_rx;
    host_tx_t               host_tx;

    int                     errors;
    logic                   seen_mmio;
    logic [LINE_ADDR_W-1:0] exp_addr;
    logic [TAG_W-1:0]       exp_tag;
    // lines in flight as seen at the ports, and the limit in force
    int                     outstanding;
    int                     cur_limit;
    logic                   req_xfer;
    logic                   rd_other;
    logic [DATA_W-1:0]      rd;

    assign host_rx = '{mmio_valid: mmio_valid, mmio_write: mmio_write, mmio_addr: mmio_addr,
                       mmio_data: mmio_data, req_ready: req_ready, rsp_valid: rsp_valid,
                       rsp_tag: rsp_tag, rsp_data: rsp_data};
    assign req_xfer = host_tx.req_valid && req_ready;
    assign rd_other = mmio_valid && !mmio_write && (mmio_addr != CSR_STATUS)
                      && (mmio_addr != CSR_CHECKSUM);

    afu_shell dut
    (
        .afu_clk   (afu_clk),
        .rst_n     (rst_n),
        .pwr_state (pwr_state),
        .error     (error),
        .host_rx   (host_rx),
        .host_tx   (host_tx)
    );

    host_mem_model host_mem
    (
        .afu_clk   (afu_clk),
        .rst_n     (rst_n),
        .req_valid (host_tx.req_valid),
        .req_addr  (host_tx.req_addr),
        .req_tag   (host_tx.req_tag),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

    initial
    begin
        afu_clk = 1'b0;
        forever #2 afu_clk = ~afu_clk;
    end

    // expected address and tag advance on every transfer at the ports
    always @(posedge afu_clk)
    begin
        if (!rst_n)
            outstanding <= 0;
        else
        begin
            outstanding <= outstanding + (req_xfer ? 1 : 0) - (rsp_valid ? 1 : 0);
            if (req_xfer)
            begin
                exp_addr <= exp_addr + 1'b1;
                exp_tag  <= exp_tag + 1'b1;
            end
        end
    end

    // ======================================================================
    // port assertions
    // ======================================================================

    mmio_rsp_on_time: assert property (@(posedge afu_clk) disable iff (!rst_n)
        mmio_valid && !mmio_write |=> host_tx.mmio_rsp_valid)
    else
    begin
        errors++;
        $display("mmio read got no response on the cycle after the request");
    end

    mmio_rsp_only_after_read: assert property (@(posedge afu_clk) disable iff (!rst_n)
        host_tx.mmio_rsp_valid |-> $past(mmio_valid && !mmio_write))
    else
    begin
        errors++;
        $display("mmio response appeared without a read one cycle before");
    end

    // addresses outside the readable map answer with zero
    mmio_other_zero: assert property (@(posedge afu_clk) disable iff (!rst_n)
        rd_other |=> host_tx.mmio_rsp_data == '0)
    else
    begin
        errors++;
        $display("MISMATCH mmio_rsp_data got %h exp %h", $sampled(host_tx.mmio_rsp_data),
                 64'h0);
    end

    req_held: assert property (@(posedge afu_clk) disable iff (!rst_n)
        host_tx.req_valid && !req_ready |=> host_tx.req_valid && $stable(host_tx.req_addr)
        && $stable(host_tx.req_tag))
    else
    begin
        errors++;
        $display("read request changed or dropped while held by back-pressure");
    end

    req_addr_order: assert property (@(posedge afu_clk) disable iff (!rst_n)
        req_xfer |-> host_tx.req_addr == exp_addr)
    else
    begin
        errors++;
        $display("MISMATCH req_addr got %h exp %h", $sampled(host_tx.req_addr),
                 $sampled(exp_addr));
    end

    req_tag_order: assert property (@(posedge afu_clk) disable iff (!rst_n)
        req_xfer |-> host_tx.req_tag == exp_tag)
    else
    begin
        errors++;
        $display("MISMATCH req_tag got %h exp %h", $sampled(host_tx.req_tag),
                 $sampled(exp_tag));
    end

    // the registered almost-full lets one extra line slip past the limit
    active_within_limit: assert property (@(posedge afu_clk) disable iff (!rst_n)
        outstanding <= cur_limit + 1)
    else
    begin
        errors++;
        $display("%0d lines outstanding with the limit at %0d", $sampled(outstanding),
                 $sampled(cur_limit));
    end

    quiet_after_reset: assert property (@(posedge afu_clk) disable iff (!rst_n)
        !seen_mmio |-> !host_tx.req_valid && !host_tx.mmio_rsp_valid)
    else
    begin
        errors++;
        $display("request or mmio response raised before any mmio access");
    end

    // ======================================================================
    // helpers
    // ======================================================================

    function automatic logic [DATA_W-1:0] line_data(input logic [LINE_ADDR_W-1:0] a);
        return {{(DATA_W-LINE_ADDR_W){1'b0}}, a} ^ DATA_XOR;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic csr_write(input logic [MMIO_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge afu_clk);
        mmio_valid <= 1'b1;
        mmio_write <= 1'b1;
        mmio_addr  <= addr;
        mmio_data  <= data;
        seen_mmio  <= 1'b1;
        @(posedge afu_clk);
        mmio_valid <= 1'b0;
        mmio_write <= 1'b0;
    endtask

    task automatic csr_read(input logic [MMIO_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int waited;
        @(posedge afu_clk);
        mmio_valid <= 1'b1;
        mmio_write <= 1'b0;
        mmio_addr  <= addr;
        seen_mmio  <= 1'b1;
        @(posedge afu_clk);
        mmio_valid <= 1'b0;
        waited = 0;
        do
        begin
            @(posedge afu_clk);
            waited++;
        end
        while (!host_tx.mmio_rsp_valid && waited < 8);
        if (!host_tx.mmio_rsp_valid)
        begin
            errors++;
            $display("no mmio response for the read of address %h", addr);
        end
        data = host_tx.mmio_rsp_data;
    endtask

    // program the limit, start a run, wait for done and read the result back
    task automatic run_lines(input int limit, input logic [LINE_ADDR_W-1:0] base,
                             input int count);
        csr_word_u         word;
        logic [DATA_W-1:0] exp_sum;
        logic [DATA_W-1:0] stat;
        int                polls;
        exp_sum = '0;
        for (int i = 0; i < count; i++)
            exp_sum += line_data(base + i);
        word = '0;
        word.limit.active_limit = limit;
        csr_write(CSR_LIMIT, word);
        cur_limit <= limit;
        exp_addr  <= base;
        exp_tag   <= '0;
        word = '0;
        word.cmd.start = 1'b1;
        word.cmd.base  = base;
        word.cmd.count = count;
        csr_write(CSR_CMD, word);
        stat  = '0;
        polls = 0;
        while (!stat[0] && polls < count * 50 + 100)
        begin
            csr_read(CSR_STATUS, stat);
            polls++;
        end
        if (!stat[0])
        begin
            errors++;
            $display("run of %0d lines at base %h never reported done", count, base);
        end
        check_value("status.rsp_count", stat[31:16], count);
        check_value("status.error", stat[1], 1'b0);
        csr_read(CSR_CHECKSUM, stat);
        check_value("checksum", stat, exp_sum);
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial
    begin
        errors      = 0;
        seen_mmio   = 1'b0;
        outstanding = 0;
        cur_limit   = MAX_ACTIVE;
        exp_addr    = '0;
        exp_tag     = '0;
        rst_n       = 1'b0;
        pwr_state   = 2'b00;
        error       = 1'b0;
        mmio_valid  = 1'b0;
        mmio_write  = 1'b0;
        mmio_addr   = '0;
        mmio_data   = '0;
        repeat (10) @(posedge afu_clk);
        rst_n <= 1'b1;
        // a quiet stretch so the idle outputs are watched before any access
        repeat (5) @(posedge afu_clk);

        pwr_state <= 2'b10;
        csr_read(CSR_STATUS, rd);
        check_value("status.pwr_state", rd[3:2], 2'b10);
        csr_read(16'h0020, rd);
        check_value("unmapped read", rd, '0);
        csr_read(CSR_CMD, rd);
        check_value("cmd read", rd, '0);

        // one cycle of error must leave the sticky bit set
        @(posedge afu_clk);
        error <= 1'b1;
        @(posedge afu_clk);
        error <= 1'b0;
        csr_read(CSR_STATUS, rd);
        check_value("status.error", rd[1], 1'b1);

        run_lines(1, 32'h0000_1000, 20);
        pwr_state <= 2'b01;
        run_lines(4, 32'h0001_0F00, 40);
        csr_read(CSR_STATUS, rd);
        check_value("status.pwr_state", rd[3:2], 2'b01);
        run_lines(64, 32'h0ABC_0000, 300);

        repeat (5) @(posedge afu_clk);
        $display("run complete with %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge afu_clk);
        $display("watchdog expired after %0d cycles, %0d errors so far", WATCHDOG_CYCLES,
                 errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/host_mem_model.sv ====
// host memory model that accepts line reads and returns them out of order after random delays
`timescale 1ns/1ps
`default_nettype none

module host_mem_model
(
    input  wire logic                                   afu_clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   req_valid,
    input  wire logic [ccip_types_pkg::LINE_ADDR_W-1:0] req_addr,
    input  wire logic [ccip_types_pkg::TAG_W-1:0]       req_tag,
    output logic                                        req_ready,
    output logic                                        rsp_valid,
    output logic [ccip_types_pkg::TAG_W-1:0]            rsp_tag,
    output logic [ccip_types_pkg::DATA_W-1:0]           rsp_data
);
    import ccip_types_pkg::*;

    // line data is the line address folded with a fixed pattern
    localparam logic [DATA_W-1:0] DATA_XOR  = 64'hA5A5_0000_5A5A_0000;
    localparam int                MAX_DELAY = 16;

    integer                 seed;
    // accepted lines still waiting for their response
    logic [LINE_ADDR_W-1:0] pend_addr[$];
    logic [TAG_W-1:0]       pend_tag[$];
    int                     pend_wait[$];
    int                     ready_idx[$];
    int                     pick;

    // outputs start low even before the first reset edge reaches the model
    initial
    begin
        seed = 20;
        req_ready <= 1'b0;
        rsp_valid <= 1'b0;
        rsp_tag   <= '0;
        rsp_data  <= '0;
    end

    always @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_tag   <= '0;
            rsp_data  <= '0;
            pend_addr.delete();
            pend_tag.delete();
            pend_wait.delete();
        end
        else
        begin
            // age every pending line and gather the ones whose delay ran out
            ready_idx.delete();
            foreach (pend_wait[i])
            begin
                if (pend_wait[i] > 0)
                    pend_wait[i]--;
                if (pend_wait[i] == 0)
                    ready_idx.push_back(i);
            end
            // one response per cycle, chosen at random among the ready lines
            if (ready_idx.size() > 0)
            begin
                pick = ready_idx[{$random(seed)} % ready_idx.size()];
                rsp_valid <= 1'b1;
                rsp_tag   <= pend_tag[pick];
                rsp_data  <= {{(DATA_W-LINE_ADDR_W){1'b0}}, pend_addr[pick]} ^ DATA_XOR;
                pend_addr.delete(pick);
                pend_tag.delete(pick);
                pend_wait.delete(pick);
            end
            else
                rsp_valid <= 1'b0;
            // a transfer uses the ready value that was on the bus this cycle
            if (req_valid && req_ready)
            begin
                pend_addr.push_back(req_addr);
                pend_tag.push_back(req_tag);
                pend_wait.push_back(1 + ({$random(seed)} % MAX_DELAY));
            end
            // ready is high about three cycles out of four
            req_ready <= ({$random(seed)} % 4) != 0;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/ccip_types_pkg.sv
design/afu_csr_pkg.sv
design/csr_decode.sv
design/active_line_tracker.sv
design/read_engine.sv
design/rsp_accumulator.sv
design/afu_shell.sv
dv/host_mem_model.sv
dv/afu_shell_tb.sv
